// File: Bender.yml
package:
  name: l1_cache_subsystem

sources:
  - source/l1_cache_pkg.sv
  - source/icache.sv
  - source/dcache.sv
  - source/mem_arbiter.sv
  - source/l1_cache_subsystem.sv
  - target: test
    files:
      - tests/wb_mem_model.sv
      - tests/tb_l1_cache_subsystem.sv

// File: source/dcache.sv
`timescale 1ns/100ps
`default_nettype none

module dcache #(
    parameter int DCACHE_LINE_BITS = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  l1_cache_pkg::data_req_t core_req,
    output l1_cache_pkg::core_rsp_t core_rsp,
    output l1_cache_pkg::mem_req_t  mem_req,
    input  l1_cache_pkg::mem_rsp_t  mem_rsp
);
    import l1_cache_pkg::*;

    localparam int LINES    = 2 ** DCACHE_LINE_BITS;
    localparam int TAG_BITS = 30 - DCACHE_LINE_BITS;

    word_t                       line_q [LINES];
    logic [TAG_BITS-1:0]         tag_q [LINES];
    logic [LINES-1:0]            valid_q;
    dc_state_e                   state_q;
    logic                        done_q;
    addr_t                       addr_q;
    sel_t                        sel_q;
    word_t                       wdata_q;

    logic [DCACHE_LINE_BITS-1:0] index;
    logic [TAG_BITS-1:0]         tag;
    logic                        hit;
    logic                        is_write;
    logic [DCACHE_LINE_BITS-1:0] req_index;
    logic [TAG_BITS-1:0]         req_tag;
    logic                        req_hit;

    assign index     = core_req.addr[DCACHE_LINE_BITS+1:2];
    assign tag       = core_req.addr[31:DCACHE_LINE_BITS+2];
    assign hit       = valid_q[index] && (tag_q[index] == tag);
    assign is_write  = (core_req.op == op_write);
    assign req_index = addr_q[DCACHE_LINE_BITS+1:2];
    assign req_tag   = addr_q[31:DCACHE_LINE_BITS+2];
    assign req_hit   = valid_q[req_index] && (tag_q[req_index] == req_tag);

    always_comb begin
        core_rsp.rdata = line_q[index];
        core_rsp.stall = 1'b1;
        if (state_q == dc_lookup) begin
            // done_q lets the finished write retire in the cycle after its ack.
            core_rsp.stall = core_req.en && (is_write ? !done_q : !hit);
        end
    end

    always_comb begin
        mem_req.valid = (state_q != dc_lookup);
        mem_req.we    = (state_q == dc_write);
        mem_req.sel   = (state_q == dc_write) ? sel_q : '1;
        mem_req.addr  = {addr_q[31:2], 2'b00};
        mem_req.wdata = wdata_q;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= dc_lookup;
            done_q  <= 1'b0;
            valid_q <= '0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                dc_lookup: begin
                    if (core_req.en && !done_q) begin
                        if (is_write) begin
                            state_q <= dc_write;  // every write goes to memory on a hit or a miss.
                        end else if (!hit) begin
                            state_q <= dc_refill;
                        end
                    end
                end
                dc_refill: begin
                    if (mem_rsp.ack) begin
                        state_q            <= dc_lookup;
                        valid_q[req_index] <= 1'b1;
                    end
                end
                dc_write: begin
                    if (mem_rsp.ack) begin
                        state_q <= dc_lookup;
                        done_q  <= 1'b1;
                    end
                end
                default: state_q <= dc_lookup;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == dc_lookup) begin
            addr_q  <= core_req.addr;
            sel_q   <= core_req.sel;
            wdata_q <= core_req.wdata;
        end
        if (state_q == dc_refill && mem_rsp.ack) begin
            line_q[req_index] <= mem_rsp.rdata;
            tag_q[req_index]  <= req_tag;
        end
        if (state_q == dc_write && mem_rsp.ack && req_hit) begin
            for (int b = 0; b < 4; b++) begin
                if (sel_q[b]) begin
                    line_q[req_index][8*b +: 8] <= wdata_q[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/icache.sv
`timescale 1ns/100ps
`default_nettype none

module icache #(
    parameter int ICACHE_LINE_BITS = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  l1_cache_pkg::inst_req_t core_req,
    output l1_cache_pkg::core_rsp_t core_rsp,
    output l1_cache_pkg::mem_req_t  mem_req,
    input  l1_cache_pkg::mem_rsp_t  mem_rsp
);
    import l1_cache_pkg::*;

    localparam int LINES    = 2 ** ICACHE_LINE_BITS;
    localparam int TAG_BITS = 30 - ICACHE_LINE_BITS;

    word_t                       line_q [LINES];
    logic [TAG_BITS-1:0]         tag_q [LINES];
    logic [LINES-1:0]            valid_q;
    logic                        pending_q;
    addr_t                       miss_addr_q;

    logic [ICACHE_LINE_BITS-1:0] index;
    logic [TAG_BITS-1:0]         tag;
    logic [ICACHE_LINE_BITS-1:0] miss_index;
    logic [TAG_BITS-1:0]         miss_tag;
    logic                        hit;

    assign index      = core_req.addr[ICACHE_LINE_BITS+1:2];
    assign tag        = core_req.addr[31:ICACHE_LINE_BITS+2];
    assign miss_index = miss_addr_q[ICACHE_LINE_BITS+1:2];
    assign miss_tag   = miss_addr_q[31:ICACHE_LINE_BITS+2];
    assign hit        = valid_q[index] && (tag_q[index] == tag);

    always_comb begin
        core_rsp.stall = core_req.en && !hit;  // held until the refilled line hits.
        core_rsp.rdata = line_q[index];
    end

    always_comb begin
        mem_req.valid = pending_q;
        mem_req.we    = 1'b0;
        mem_req.sel   = '1;
        mem_req.addr  = {miss_addr_q[31:2], 2'b00};
        mem_req.wdata = '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
            valid_q   <= '0;
        end else if (pending_q) begin
            if (mem_rsp.ack) begin
                pending_q           <= 1'b0;
                valid_q[miss_index] <= 1'b1;
            end
        end else if (core_req.en && !hit) begin
            pending_q <= 1'b1;
        end
    end

    // The miss address is frozen for the whole refill.
    always_ff @(posedge clk) begin
        if (!pending_q && core_req.en && !hit) begin
            miss_addr_q <= core_req.addr;
        end
        if (pending_q && mem_rsp.ack) begin
            line_q[miss_index] <= mem_rsp.rdata;
            tag_q[miss_index]  <= miss_tag;
        end
    end

endmodule

`default_nettype wire

// File: source/l1_cache_pkg.sv
`default_nettype none

package l1_cache_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;  // bits 1:0 are ignored because every access is a whole word.
    typedef logic [3:0]  sel_t;

    typedef enum logic [1:0] {
        op_read  = 2'd0,
        op_write = 2'd1
    } data_op_e;

    typedef struct packed {
        logic  en;
        addr_t addr;
    } inst_req_t;

    typedef struct packed {
        logic     en;
        data_op_e op;
        sel_t     sel;
        addr_t    addr;
        word_t    wdata;
    } data_req_t;

    typedef struct packed {
        logic  stall;
        word_t rdata;
    } core_rsp_t;

    typedef struct packed {
        logic  valid;
        logic  we;
        sel_t  sel;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  ack;
        word_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        sel_t  sel;
        addr_t adr;
        word_t dat;
    } wb_m2s_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_s2m_t;

    typedef enum logic [1:0] {
        arb_idle,
        arb_inst,
        arb_data
    } arb_state_e;

    typedef enum logic [1:0] {
        dc_lookup,
        dc_refill,
        dc_write
    } dc_state_e;

endpackage

`default_nettype wire

// File: source/l1_cache_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module l1_cache_subsystem #(
    parameter int ICACHE_LINE_BITS = 4,
    parameter int DCACHE_LINE_BITS = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  l1_cache_pkg::inst_req_t inst_req,
    output l1_cache_pkg::core_rsp_t inst_rsp,
    input  l1_cache_pkg::data_req_t data_req,
    output l1_cache_pkg::core_rsp_t data_rsp,
    output l1_cache_pkg::wb_m2s_t   wb_out,
    input  l1_cache_pkg::wb_s2m_t   wb_in
);
    import l1_cache_pkg::*;

    mem_req_t inst_mem_req;
    mem_rsp_t inst_mem_rsp;
    mem_req_t data_mem_req;
    mem_rsp_t data_mem_rsp;

    icache #(
        .ICACHE_LINE_BITS(ICACHE_LINE_BITS)
    ) icache_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .core_req(inst_req),
        .core_rsp(inst_rsp),
        .mem_req (inst_mem_req),
        .mem_rsp (inst_mem_rsp)
    );

    dcache #(
        .DCACHE_LINE_BITS(DCACHE_LINE_BITS)
    ) dcache_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .core_req(data_req),
        .core_rsp(data_rsp),
        .mem_req (data_mem_req),
        .mem_rsp (data_mem_rsp)
    );

    mem_arbiter mem_arbiter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_mem_req(inst_mem_req),
        .inst_mem_rsp(inst_mem_rsp),
        .data_mem_req(data_mem_req),
        .data_mem_rsp(data_mem_rsp),
        .wb_out      (wb_out),
        .wb_in       (wb_in)
    );

endmodule

`default_nettype wire

// File: source/mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  l1_cache_pkg::mem_req_t inst_mem_req,
    output l1_cache_pkg::mem_rsp_t inst_mem_rsp,
    input  l1_cache_pkg::mem_req_t data_mem_req,
    output l1_cache_pkg::mem_rsp_t data_mem_rsp,
    output l1_cache_pkg::wb_m2s_t  wb_out,
    input  l1_cache_pkg::wb_s2m_t  wb_in
);
    import l1_cache_pkg::*;

    arb_state_e state_q;
    logic       we_q;
    sel_t       sel_q;
    addr_t      adr_q;
    word_t      dat_q;
    mem_req_t   pick;

    // data cache has fixed priority over the instruction cache.
    assign pick = data_mem_req.valid ? data_mem_req : inst_mem_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= arb_idle;
        end else begin
            case (state_q)
                arb_idle: begin
                    if (pick.valid) begin
                        state_q <= data_mem_req.valid ? arb_data : arb_inst;
                    end
                end
                arb_inst, arb_data: begin
                    if (wb_in.ack) begin
                        state_q <= arb_idle;  // one single-word cycle per grant.
                    end
                end
                default: state_q <= arb_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == arb_idle) begin
            we_q  <= pick.we;
            sel_q <= pick.sel;
            adr_q <= pick.addr;
            dat_q <= pick.wdata;
        end
    end

    always_comb begin
        wb_out.cyc = (state_q != arb_idle);
        wb_out.stb = (state_q != arb_idle);
        wb_out.we  = we_q;
        wb_out.sel = sel_q;
        wb_out.adr = adr_q;
        wb_out.dat = dat_q;
    end

    always_comb begin
        inst_mem_rsp.ack   = (state_q == arb_inst) && wb_in.ack;
        inst_mem_rsp.rdata = wb_in.dat;
        data_mem_rsp.ack   = (state_q == arb_data) && wb_in.ack;
        data_mem_rsp.rdata = wb_in.dat;
    end

endmodule

`default_nettype wire

// File: tests/tb_l1_cache_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module tb_l1_cache_subsystem;
    import l1_cache_pkg::*;

    localparam int    ICACHE_LINE_BITS = 4;
    localparam int    DCACHE_LINE_BITS = 4;
    localparam word_t PATTERN          = 32'h5a5a_0000;

    typedef struct {
        inst_req_t inst;
        data_req_t data;
        word_t     exp_inst;
        word_t     exp_data;
        int        exp_count;
        logic      check_order;
        addr_t     first_adr;
    } entry_t;

    logic      clk = 1'b0;
    logic      rst_n;
    inst_req_t inst_req;
    core_rsp_t inst_rsp;
    data_req_t data_req;
    core_rsp_t data_rsp;
    wb_m2s_t   wb_out;
    wb_s2m_t   wb_in;

    entry_t    stim_q [$];
    addr_t     bus_log [$];
    int        bus_count = 0;
    int        cycle_count = 0;
    int        timeout_limit = 0;
    int        word_errors = 0;
    int        count_errors = 0;
    int        order_errors = 0;

    always #10 clk = ~clk;

    l1_cache_subsystem #(
        .ICACHE_LINE_BITS(ICACHE_LINE_BITS),
        .DCACHE_LINE_BITS(DCACHE_LINE_BITS)
    ) dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .inst_req(inst_req),
        .inst_rsp(inst_rsp),
        .data_req(data_req),
        .data_rsp(data_rsp),
        .wb_out  (wb_out),
        .wb_in   (wb_in)
    );

    wb_mem_model #(
        .SEED   (32'h8a2b_a66a),
        .PATTERN(PATTERN)
    ) mem_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus_in (wb_out),
        .bus_out(wb_in)
    );

    // one count per completed Wishbone cycle.
    always @(negedge clk) begin
        if (rst_n && wb_out.cyc && wb_in.ack) begin
            bus_count++;
            bus_log.push_back(wb_out.adr);
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= timeout_limit) begin
                $display("run hung waiting for stall to fall after %0d cycles", cycle_count);
                $display("Result: FAILED");
                $finish;
            end
        end
    end

    function automatic word_t pattern(addr_t a);
        return {a[31:2], 2'b00} ^ PATTERN;
    endfunction

    function automatic word_t merge(word_t old, word_t wdata, sel_t sel);
        word_t w;
        w = old;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                w[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return w;
    endfunction

    function automatic inst_req_t inst_read(addr_t a);
        return {1'b1, a};
    endfunction

    function automatic data_req_t data_read(addr_t a);
        return {1'b1, op_read, 4'b1111, a, 32'h0};
    endfunction

    function automatic data_req_t data_write(addr_t a, sel_t sel, word_t wdata);
        return {1'b1, op_write, sel, a, wdata};
    endfunction

    task automatic check_word(string what, word_t actual, word_t expected);
        if (actual !== expected) begin
            word_errors++;
            $display("ERROR %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_addr(string what, addr_t actual, addr_t expected);
        if (actual !== expected) begin
            order_errors++;
            $display("ERROR %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_count(string what, int actual, int expected);
        if (actual != expected) begin
            count_errors++;
            $display("ERROR %0t: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic add_entry(inst_req_t inst, data_req_t data, word_t exp_inst,
                             word_t exp_data, int exp_count, logic check_order,
                             addr_t first_adr);
        entry_t e;
        e.inst        = inst;
        e.data        = data;
        e.exp_inst    = exp_inst;
        e.exp_data    = exp_data;
        e.exp_count   = exp_count;
        e.check_order = check_order;
        e.first_adr   = first_adr;
        stim_q.push_back(e);
    endtask

    task automatic build_stimulus();
        addr_t i_alias;
        addr_t d_alias;
        word_t w1000;
        word_t w2004;
        i_alias = 32'h104 + (32'd4 << ICACHE_LINE_BITS);  // same index as 0x104.
        d_alias = 32'h1000 + (32'd4 << DCACHE_LINE_BITS);
        w1000   = merge(pattern(32'h1000), 32'hdead_beef, 4'b0011);
        w2004   = merge(pattern(32'h2004), 32'h1234_5678, 4'b1100);
        add_entry(inst_read(32'h104), '0, pattern(32'h104), '0, 1, 1'b0, '0);
        add_entry('0, data_read(32'h1000), '0, pattern(32'h1000), 2, 1'b0, '0);
        add_entry(inst_read(32'h104), data_read(32'h1000), pattern(32'h104),
                  pattern(32'h1000), 2, 1'b0, '0);
        add_entry('0, data_write(32'h1000, 4'b0011, 32'hdead_beef), '0, '0, 3, 1'b0, '0);
        add_entry('0, data_read(32'h1000), '0, w1000, 3, 1'b0, '0);
        add_entry('0, data_write(32'h2004, 4'b1100, 32'h1234_5678), '0, '0, 4, 1'b0, '0);
        add_entry('0, data_read(32'h2004), '0, w2004, 5, 1'b0, '0);
        add_entry(inst_read(32'h208), data_read(32'h3008), pattern(32'h208),
                  pattern(32'h3008), 7, 1'b1, 32'h3008);
        add_entry(inst_read(32'h208), data_read(d_alias), pattern(32'h208),
                  pattern(d_alias), 8, 1'b0, '0);
        add_entry(inst_read(i_alias), data_read(32'h1000), pattern(i_alias),
                  w1000, 10, 1'b1, 32'h1000);
        add_entry(inst_read(32'h104), data_read(32'h1000), pattern(32'h104),
                  w1000, 11, 1'b0, '0);
        add_entry(inst_read(32'h30c), data_write(32'h3008, 4'b1111, 32'hcafe_f00d),
                  pattern(32'h30c), '0, 13, 1'b1, 32'h3008);
        add_entry(inst_read(32'h30c), data_read(32'h3008), pattern(32'h30c),
                  32'hcafe_f00d, 13, 1'b0, '0);
    endtask

    // each port drops its request in the cycle after its stall falls.
    task automatic apply_entry(int idx, entry_t e, int prev_count);
        word_t got_inst;
        word_t got_data;
        logic  inst_busy;
        logic  data_busy;
        int    start_count;
        int    loops;
        start_count = bus_count;
        loops       = 0;
        @(posedge clk);
        inst_req  <= e.inst;
        data_req  <= e.data;
        inst_busy = e.inst.en;
        data_busy = e.data.en;
        while (inst_busy || data_busy) begin
            @(negedge clk);
            loops++;
            if (inst_busy && !inst_rsp.stall) begin
                got_inst  = inst_rsp.rdata;
                inst_busy = 1'b0;
            end
            if (data_busy && !data_rsp.stall) begin
                got_data  = data_rsp.rdata;
                data_busy = 1'b0;
            end
            @(posedge clk);
            if (!inst_busy) begin
                inst_req.en <= 1'b0;
            end
            if (!data_busy) begin
                data_req.en <= 1'b0;
            end
        end
        if (e.inst.en) begin
            check_word($sformatf("entry %0d instruction rdata", idx), got_inst, e.exp_inst);
        end
        if (e.data.en && e.data.op == op_read) begin
            check_word($sformatf("entry %0d data rdata", idx), got_data, e.exp_data);
        end
        check_count($sformatf("entry %0d bus cycles", idx), bus_count, e.exp_count);
        // an entry that adds no bus cycle is all hits and retires in its first cycle.
        if (e.exp_count == prev_count) begin
            check_count($sformatf("entry %0d cycles to retire", idx), loops, 1);
        end
        if (e.check_order) begin
            check_addr($sformatf("entry %0d first bus address", idx), bus_log[start_count],
                       e.first_adr);
        end
    endtask

    initial begin
        inst_req = '0;
        data_req = '0;
        rst_n    = 1'b0;
        build_stimulus();
        timeout_limit = stim_q.size() * 4 * (3 + 4);
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        foreach (stim_q[i]) begin
            apply_entry(i, stim_q[i], (i == 0) ? 0 : stim_q[i-1].exp_count);
        end
        $display("errors: rdata %0d, cycle counts %0d, bus order %0d",
                 word_errors, count_errors, order_errors);
        if (word_errors + count_errors + order_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/wb_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module wb_mem_model #(
    parameter logic [31:0] SEED    = 32'h8a2b_a66a,
    parameter logic [31:0] PATTERN = 32'h5a5a_0000
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  l1_cache_pkg::wb_m2s_t bus_in,
    output l1_cache_pkg::wb_s2m_t bus_out
);
    import l1_cache_pkg::*;

    word_t      mem [addr_t];  // only words that were written are stored.
    integer     seed = SEED;
    logic       busy_q;
    logic [1:0] wait_q;
    addr_t      adr;

    assign adr = {bus_in.adr[31:2], 2'b00};

    function automatic word_t read_word(addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ PATTERN;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        word_t merged;
        if (!rst_n) begin
            busy_q  <= 1'b0;
            wait_q  <= '0;
            bus_out <= '0;
        end else begin
            bus_out.ack <= 1'b0;
            if (bus_in.cyc && bus_in.stb && !bus_out.ack) begin
                if (!busy_q) begin
                    busy_q <= 1'b1;
                    wait_q <= 2'($random(seed));  // 0 to 3 wait states per cycle.
                end else if (wait_q != 2'd0) begin
                    wait_q <= wait_q - 2'd1;
                end else begin
                    busy_q      <= 1'b0;
                    bus_out.ack <= 1'b1;
                    bus_out.dat <= read_word(adr);
                    if (bus_in.we) begin
                        merged = read_word(adr);
                        for (int b = 0; b < 4; b++) begin
                            if (bus_in.sel[b]) begin
                                merged[8*b +: 8] = bus_in.dat[8*b +: 8];
                            end
                        end
                        mem[adr] = merged;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
source/l1_cache_pkg.sv
source/icache.sv
source/dcache.sv
source/mem_arbiter.sv
source/l1_cache_subsystem.sv
tests/wb_mem_model.sv
tests/tb_l1_cache_subsystem.sv
